// ==== flist.f ====
hdl/madam_pkg.sv
hdl/madam_reg_file.sv
hdl/madam_msb_finder.sv
hdl/madam_pcsc_capture.sv
hdl/madam_top.sv
verif/madam_asserts.sv
verif/madam_tb.sv

// ==== hdl/madam_msb_finder.sv ====
// Most significant bit finder at offset 0x002C.
// A read returns the index of the highest set bit of the last written word.
// A stored zero reads MSB_NONE_VALUE.
// msb_hit is a pure offset decode; the top level uses it to steer cpu_dout.

`timescale 1ns/1ps

module madam_msb_finder import madam_pkg::*; (
	input  logic        clk_25m,
	input  logic        reset_n,
	input  reg_offset_t reg_offset,
	input  word_t       cpu_din,
	input  logic        cpu_wr,
	output logic        msb_hit,	// offset is 0x002C.
	output word_t       msb_rdata	// bit index or all ones.
);

	word_t msb_value;	// last word written at 0x002C.

	assign msb_hit = (reg_offset == OFS_MSB_CHECK);

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			msb_value <= '0;
		end else if (cpu_wr && msb_hit) begin
			msb_value <= cpu_din;
		end
	end

	// scan upward, so the last set bit found is the highest one.
	always_comb begin
		msb_rdata = MSB_NONE_VALUE;
		for (int i = 0; i < 32; i++) begin
			if (msb_value[i]) begin
				msb_rdata = word_t'(i);
			end
		end
	end

endmodule

// ==== hdl/madam_pcsc_capture.sv ====
// Line flag capture from the pcsc strobe.
// A rising pcsc while idle restarts hcount and starts a seven bit capture.
// Flag bit k takes pcsc at the k-th edge after the start; bit 0 stays zero.
// Edges during the capture are ignored. HCOUNT_W must be at least 4.

`timescale 1ns/1ps

module madam_pcsc_capture import madam_pkg::*; #(
	parameter int HCOUNT_W = 12		// horizontal counter width.
) (
	input  logic                clk_25m,
	input  logic                reset_n,
	input  logic                pcsc,
	output logic [HCOUNT_W-1:0] hcount,		// pixel clock count since line start.
	output line_flags_t         line_flags	// vl, vd, vr, fc, f, v, vz from bit 7 down.
);

	logic       pcsc_dly;		// pcsc one cycle late.
	logic       pcsc_rising;
	bit_index_t bit_index;		// zero when idle, 1 to 7 while shifting.

	assign pcsc_rising = pcsc && !pcsc_dly;

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			pcsc_dly <= 1'b0;
		end else begin
			pcsc_dly <= pcsc;
		end
	end

	// line start restarts the counter, otherwise free running.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			hcount <= '0;
		end else if (pcsc_rising && bit_index == '0) begin
			hcount <= '0;
		end else begin
			hcount <= hcount + 1'b1;	// wraps at full count.
		end
	end

	// bit index runs 1..7 then wraps to idle.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			bit_index <= '0;
		end else if (bit_index != '0) begin
			bit_index <= bit_index + 1'b1;
		end else if (pcsc_rising) begin
			bit_index <= 3'd1;		// accepted line start.
		end
	end

	// flags shift in at the current index.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			line_flags <= '0;
		end else if (bit_index != '0) begin
			line_flags[bit_index] <= pcsc;	// index is never zero here.
		end
	end

endmodule

// ==== hdl/madam_pkg.sv ====
// Shared types and constants for the MADAM CPU register block.
// Offsets are byte offsets within the MADAM window, taken from cpu_addr[15:0].
// PPMPC is decoded at 0x0129 and is not word aligned.
// Only DMA groups 0x0 and 0xC are mapped, with 22-bit fields.

package madam_pkg;

	typedef logic [31:0] word_t;		// cpu data word.
	typedef logic [15:0] reg_offset_t;	// low half of cpu_addr.
	typedef logic [21:0] dma_field_t;	// dma address or length, covers 4 MB.
	typedef logic [7:0]  line_flags_t;	// bit 0 unused, bits 7:1 are the line flags.
	typedef logic [10:0] modulo_t;		// frame buffer modulo in pixels.
	typedef logic [2:0]  bit_index_t;	// flag bit being shifted in.

	// identity and general control.
	localparam reg_offset_t OFS_REVISION   = 16'h0000;
	localparam reg_offset_t OFS_MSYSBITS   = 16'h0004;
	localparam reg_offset_t OFS_MCTL       = 16'h0008;	// dma enables, reads zero.
	localparam reg_offset_t OFS_SLTIME     = 16'h000C;
	localparam reg_offset_t OFS_ABORTBITS  = 16'h0020;
	localparam reg_offset_t OFS_PRIVBITS   = 16'h0024;
	localparam reg_offset_t OFS_STATBITS   = 16'h0028;
	localparam reg_offset_t OFS_MSB_CHECK  = 16'h002C;	// handled by the msb finder.
	localparam reg_offset_t OFS_DIAG       = 16'h0040;

	// sprite engine control.
	localparam reg_offset_t OFS_CCOBCTL0   = 16'h0110;
	localparam reg_offset_t OFS_PPMPC      = 16'h0129;
	localparam reg_offset_t OFS_REGCTL0    = 16'h0130;	// read and write modulo.
	localparam reg_offset_t OFS_REGCTL1    = 16'h0134;	// x and y clip.
	localparam reg_offset_t OFS_REGCTL2    = 16'h0138;	// read base address.
	localparam reg_offset_t OFS_REGCTL3    = 16'h013C;	// write base address.

	// position and slope words.
	localparam reg_offset_t OFS_XYPOSH     = 16'h0140;
	localparam reg_offset_t OFS_XYPOSL     = 16'h0144;
	localparam reg_offset_t OFS_LINEDXYH   = 16'h0148;
	localparam reg_offset_t OFS_LINEDXYL   = 16'h014C;
	localparam reg_offset_t OFS_DXYH       = 16'h0150;
	localparam reg_offset_t OFS_DXYL       = 16'h0154;
	localparam reg_offset_t OFS_DDXYH      = 16'h0158;
	localparam reg_offset_t OFS_DDXYL      = 16'h015C;

	// fence words sit in two separate ranges.
	localparam reg_offset_t OFS_FENCE_0L   = 16'h0230;
	localparam reg_offset_t OFS_FENCE_0R   = 16'h0234;
	localparam reg_offset_t OFS_FENCE_1L   = 16'h0238;
	localparam reg_offset_t OFS_FENCE_1R   = 16'h023C;
	localparam reg_offset_t OFS_FENCE_2L   = 16'h0270;
	localparam reg_offset_t OFS_FENCE_2R   = 16'h0274;
	localparam reg_offset_t OFS_FENCE_3L   = 16'h0278;
	localparam reg_offset_t OFS_FENCE_3R   = 16'h027C;

	// cpu ram to dsp dma, groups 0x0 and 0xC.
	localparam reg_offset_t OFS_DMA0_CURADDR  = 16'h0400;
	localparam reg_offset_t OFS_DMA0_CURLEN   = 16'h0404;
	localparam reg_offset_t OFS_DMA0_NEXTADDR = 16'h0408;
	localparam reg_offset_t OFS_DMA0_NEXTLEN  = 16'h040C;
	localparam reg_offset_t OFS_DMAC_CURADDR  = 16'h04C0;
	localparam reg_offset_t OFS_DMAC_CURLEN   = 16'h04C4;
	localparam reg_offset_t OFS_DMAC_NEXTADDR = 16'h04C8;
	localparam reg_offset_t OFS_DMAC_NEXTLEN  = 16'h04CC;

	localparam reg_offset_t OFS_VDL_ADDR   = 16'h0580;	// video display list.

	// fixed read values.
	localparam word_t REVISION_VALUE = 32'h0102_0000;
	localparam word_t MSYSBITS_VALUE = 32'h0000_0029;	// 2 MB dram and 1 MB vram.
	localparam word_t UNMAPPED_VALUE = 32'hBADA_CCE5;
	localparam word_t MSB_NONE_VALUE = 32'hFFFF_FFFF;	// msb finder result for zero.

endpackage

// ==== hdl/madam_reg_file.sv ====
// MADAM general register map.
// Revision, memory configuration and the dma enable word are read only.
// DMA fields keep cpu_din[21:0] and read back zero extended.
// Every offset not listed here, 0x002C included, reads UNMAPPED_VALUE.
// rmod and wmod follow REGCTL0 one cycle after its write.

`timescale 1ns/1ps

module madam_reg_file import madam_pkg::*; (
	input  logic        clk_25m,
	input  logic        reset_n,
	input  reg_offset_t reg_offset,
	input  word_t       cpu_din,
	input  logic        cpu_wr,
	output word_t       reg_rdata,
	output modulo_t     rmod,	// source frame buffer modulo.
	output modulo_t     wmod	// destination frame buffer modulo.
);

	localparam int WORD_COUNT = 28;		// full width registers.
	localparam int DMA_COUNT  = 8;		// two dma groups of four fields.
	localparam int WORD_SEL_W = $clog2(WORD_COUNT);
	localparam int DMA_SEL_W  = $clog2(DMA_COUNT);
	localparam logic [WORD_SEL_W-1:0] SLOT_REGCTL0 = 5'd7;

	word_t      word_regs [WORD_COUNT];	// general, sprite, position, fence and vdl words.
	dma_field_t dma_regs  [DMA_COUNT];	// dma0 then dmac, curaddr/curlen/nextaddr/nextlen.

	logic                  word_hit;	// offset maps to a full width register.
	logic [WORD_SEL_W-1:0] word_sel;
	logic                  dma_hit;		// offset maps to a dma field.
	logic [DMA_SEL_W-1:0]  dma_sel;
	word_t                 regctl0;

	// bit 0 is weight 128, bits 3:2 weights 512/256, bits 6:4 weights 64/32/16.
	function automatic modulo_t modulo_decode(input logic [7:0] ctl);
		return {1'b0, ctl[3:2], ctl[0], ctl[6:4], 4'b0000};
	endfunction

	// full width register slots.
	always_comb begin
		word_hit = 1'b1;
		word_sel = '0;
		case (reg_offset)
			OFS_SLTIME:    word_sel = 5'd0;
			OFS_ABORTBITS: word_sel = 5'd1;		// abort reasons.
			OFS_PRIVBITS:  word_sel = 5'd2;		// dma privilege violations.
			OFS_STATBITS:  word_sel = 5'd3;		// sprite engine status.
			OFS_DIAG:      word_sel = 5'd4;
			OFS_CCOBCTL0:  word_sel = 5'd5;
			OFS_PPMPC:     word_sel = 5'd6;
			OFS_REGCTL0:   word_sel = 5'd7;
			OFS_REGCTL1:   word_sel = 5'd8;
			OFS_REGCTL2:   word_sel = 5'd9;
			OFS_REGCTL3:   word_sel = 5'd10;
			OFS_XYPOSH:    word_sel = 5'd11;
			OFS_XYPOSL:    word_sel = 5'd12;
			OFS_LINEDXYH:  word_sel = 5'd13;
			OFS_LINEDXYL:  word_sel = 5'd14;
			OFS_DXYH:      word_sel = 5'd15;
			OFS_DXYL:      word_sel = 5'd16;
			OFS_DDXYH:     word_sel = 5'd17;
			OFS_DDXYL:     word_sel = 5'd18;
			OFS_FENCE_0L:  word_sel = 5'd19;
			OFS_FENCE_0R:  word_sel = 5'd20;
			OFS_FENCE_1L:  word_sel = 5'd21;
			OFS_FENCE_1R:  word_sel = 5'd22;
			OFS_FENCE_2L:  word_sel = 5'd23;
			OFS_FENCE_2R:  word_sel = 5'd24;
			OFS_FENCE_3L:  word_sel = 5'd25;
			OFS_FENCE_3R:  word_sel = 5'd26;
			OFS_VDL_ADDR:  word_sel = 5'd27;
			default:       word_hit = 1'b0;
		endcase
	end

	// dma field slots.
	always_comb begin
		dma_hit = 1'b1;
		dma_sel = '0;
		case (reg_offset)
			OFS_DMA0_CURADDR:  dma_sel = 3'd0;
			OFS_DMA0_CURLEN:   dma_sel = 3'd1;
			OFS_DMA0_NEXTADDR: dma_sel = 3'd2;
			OFS_DMA0_NEXTLEN:  dma_sel = 3'd3;
			OFS_DMAC_CURADDR:  dma_sel = 3'd4;
			OFS_DMAC_CURLEN:   dma_sel = 3'd5;
			OFS_DMAC_NEXTADDR: dma_sel = 3'd6;
			OFS_DMAC_NEXTLEN:  dma_sel = 3'd7;
			default:           dma_hit = 1'b0;
		endcase
	end

	// register writes.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < WORD_COUNT; i++) begin
				word_regs[i] <= '0;
			end
			for (int i = 0; i < DMA_COUNT; i++) begin
				dma_regs[i] <= '0;
			end
		end else if (cpu_wr) begin
			if (word_hit) begin
				word_regs[word_sel] <= cpu_din;
			end
			if (dma_hit) begin
				dma_regs[dma_sel] <= cpu_din[21:0];	// upper bits dropped.
			end
		end
	end

	// read mux, combinational on the offset.
	always_comb begin
		reg_rdata = UNMAPPED_VALUE;
		case (reg_offset)
			OFS_REVISION: reg_rdata = REVISION_VALUE;
			OFS_MSYSBITS: reg_rdata = MSYSBITS_VALUE;
			OFS_MCTL:     reg_rdata = '0;		// writes are ignored.
			default: begin
				if (word_hit) begin
					reg_rdata = word_regs[word_sel];
				end else if (dma_hit) begin
					reg_rdata = word_t'(dma_regs[dma_sel]);
				end
			end
		endcase
	end

	assign regctl0 = word_regs[SLOT_REGCTL0];

	// read modulo in the low byte, write modulo in the next.
	assign rmod = modulo_decode(regctl0[7:0]);
	assign wmod = modulo_decode(regctl0[15:8]);

endmodule

// ==== hdl/madam_top.sv ====
// MADAM CPU register block top level.
// Only cpu_addr[15:0] is decoded, so the map repeats every 64 KB of the window.
// Reads are combinational on cpu_addr; writes land on the edge that samples cpu_wr.
// HCOUNT_W must be at least 4.

`timescale 1ns/1ps

module madam_top import madam_pkg::*; #(
	parameter int HCOUNT_W = 12		// horizontal counter width.
) (
	input  logic                clk_25m,
	input  logic                reset_n,

	input  word_t               cpu_addr,
	input  word_t               cpu_din,
	input  logic                cpu_wr,		// one cycle write strobe.
	output word_t               cpu_dout,	// read data for cpu_addr, same cycle.

	input  logic                pcsc,		// serial line flags from the video side.
	output logic [HCOUNT_W-1:0] hcount,
	output line_flags_t         line_flags,

	output modulo_t             rmod,
	output modulo_t             wmod
);

	reg_offset_t reg_offset;	// offset within the madam window.
	word_t       reg_rdata;		// register file read data.
	word_t       msb_rdata;		// msb finder read data.
	logic        msb_hit;		// offset belongs to the msb finder.

	assign reg_offset = cpu_addr[15:0];

	// general registers, identity words, dma fields and modulo decode.
	madam_reg_file madam_reg_file_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.reg_offset (reg_offset),
		.cpu_din    (cpu_din),
		.cpu_wr     (cpu_wr),
		.reg_rdata  (reg_rdata),
		.rmod       (rmod),
		.wmod       (wmod)
	);

	// highest set bit of the word written at 0x002C.
	madam_msb_finder madam_msb_finder_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.reg_offset (reg_offset),
		.cpu_din    (cpu_din),
		.cpu_wr     (cpu_wr),
		.msb_hit    (msb_hit),
		.msb_rdata  (msb_rdata)
	);

	// line start detection and flag deserializer.
	madam_pcsc_capture #(
		.HCOUNT_W (HCOUNT_W)
	) madam_pcsc_capture_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.pcsc       (pcsc),
		.hcount     (hcount),
		.line_flags (line_flags)
	);

	// the register file returns the unmapped value at 0x002C, so the finder wins there.
	assign cpu_dout = msb_hit ? msb_rdata : reg_rdata;

endmodule

// ==== verif/madam_asserts.sv ====
// Protocol checks for the pcsc capture, bound into madam_pcsc_capture.
// Checks are off while reset_n is low.
// assert_fail_count counts failures so the testbench can see them.

`timescale 1ns/1ps

module madam_asserts import madam_pkg::*; #(
	parameter int HCOUNT_W = 12
) (
	input logic                clk_25m,
	input logic                reset_n,
	input logic                pcsc_rising,
	input bit_index_t          bit_index,
	input logic [HCOUNT_W-1:0] hcount,
	input line_flags_t         line_flags
);

	int assert_fail_count = 0;

	// idle index stays idle unless a line start is seen.
	idle_needs_edge: assert property (@(posedge clk_25m) disable iff (!reset_n)
		(bit_index == '0 && !pcsc_rising) |=> (bit_index == '0))
		else begin
			assert_fail_count++;
			$error("bit index left idle without a rising pcsc");
		end

	// accepted line start clears the horizontal counter.
	hcount_restart: assert property (@(posedge clk_25m) disable iff (!reset_n)
		(bit_index == '0 && pcsc_rising) |=> (hcount == '0))
		else begin
			assert_fail_count++;
			$error("hcount not zero after an accepted line start");
		end

	flag_bit0_zero: assert property (@(posedge clk_25m) disable iff (!reset_n)
		line_flags[0] == 1'b0)
		else begin
			assert_fail_count++;
			$error("line_flags bit 0 is set");
		end

endmodule

bind madam_pcsc_capture madam_asserts #(
	.HCOUNT_W (HCOUNT_W)
) madam_asserts_inst (
	.clk_25m     (clk_25m),
	.reset_n     (reset_n),
	.pcsc_rising (pcsc_rising),
	.bit_index   (bit_index),
	.hcount      (hcount),
	.line_flags  (line_flags)
);

// ==== verif/madam_tb.sv ====
// Testbench for the MADAM register block.
// Inputs change on the falling clock edge; cpu_dout is compared on the rising edge.
// Expected reads come from a model of the register map that tracks every write.
// Random data comes from a Galois LFSR seeded with 32'h945b, one step per bit.
// Stops at the first mismatch; a watchdog ends a hung run.

`timescale 1ns/1ps

module madam_tb;
	import madam_pkg::*;

	localparam int CLK_PERIOD   = 40;		// 25 MHz.
	localparam int RESET_CYCLES = 5;
	localparam int HCOUNT_W     = 12;
	localparam int WRITE_ROUNDS = 3;		// passes over the writable map.
	localparam int MSB_COUNT    = 24;
	localparam int MOD_COUNT    = 16;
	localparam int LINE_COUNT   = 12;		// random lines, two fixed ones come on top.
	localparam int REG_COUNT    = 36;
	localparam int OP_COUNT     = REG_COUNT + 8 + WRITE_ROUNDS * REG_COUNT + 4 + MSB_COUNT
		+ MOD_COUNT;
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 3 * OP_COUNT + 12 * (LINE_COUNT + 2));
	localparam logic [31:0] LFSR_SEED = 32'h945b;

	// every offset that stores a value, dma fields last.
	localparam reg_offset_t WRITABLE_OFS [REG_COUNT] = '{
		OFS_SLTIME, OFS_ABORTBITS, OFS_PRIVBITS, OFS_STATBITS, OFS_DIAG,
		OFS_CCOBCTL0, OFS_PPMPC, OFS_REGCTL0, OFS_REGCTL1, OFS_REGCTL2, OFS_REGCTL3,
		OFS_XYPOSH, OFS_XYPOSL, OFS_LINEDXYH, OFS_LINEDXYL,
		OFS_DXYH, OFS_DXYL, OFS_DDXYH, OFS_DDXYL,
		OFS_FENCE_0L, OFS_FENCE_0R, OFS_FENCE_1L, OFS_FENCE_1R,
		OFS_FENCE_2L, OFS_FENCE_2R, OFS_FENCE_3L, OFS_FENCE_3R, OFS_VDL_ADDR,
		OFS_DMA0_CURADDR, OFS_DMA0_CURLEN, OFS_DMA0_NEXTADDR, OFS_DMA0_NEXTLEN,
		OFS_DMAC_CURADDR, OFS_DMAC_CURLEN, OFS_DMAC_NEXTADDR, OFS_DMAC_NEXTLEN
	};

	logic                clk_25m;
	logic                reset_n;
	word_t               cpu_addr;
	word_t               cpu_din;
	logic                cpu_wr;
	word_t               cpu_dout;
	logic                pcsc;
	logic [HCOUNT_W-1:0] hcount;
	line_flags_t         line_flags;
	modulo_t             rmod;
	modulo_t             wmod;

	logic        check_en;		// compare cpu_dout at the next rising edge.
	logic [31:0] lfsr_state;
	word_t       model_regs [reg_offset_t];	// stored values, raw as written.
	word_t       model_msb;		// last word written at 0x002C.

	madam_top #(
		.HCOUNT_W (HCOUNT_W)
	) madam_top_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.cpu_addr   (cpu_addr),
		.cpu_din    (cpu_din),
		.cpu_wr     (cpu_wr),
		.cpu_dout   (cpu_dout),
		.pcsc       (pcsc),
		.hcount     (hcount),
		.line_flags (line_flags),
		.rmod       (rmod),
		.wmod       (wmod)
	);

	always #(CLK_PERIOD / 2) clk_25m = ~clk_25m;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1.
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit taken, msb first.
	task automatic random_bits(input int count, output word_t value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic is_writable(input reg_offset_t ofs);
		foreach (WRITABLE_OFS[i]) begin
			if (WRITABLE_OFS[i] == ofs) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic logic is_dma(input reg_offset_t ofs);
		return ofs inside {OFS_DMA0_CURADDR, OFS_DMA0_CURLEN, OFS_DMA0_NEXTADDR,
			OFS_DMA0_NEXTLEN, OFS_DMAC_CURADDR, OFS_DMAC_CURLEN, OFS_DMAC_NEXTADDR,
			OFS_DMAC_NEXTLEN};
	endfunction

	// highest set bit, scanned from the top down.
	function automatic word_t msb_index(input word_t value);
		for (int i = 31; i >= 0; i--) begin
			if (value[i]) begin
				return word_t'(i);
			end
		end
		return MSB_NONE_VALUE;
	endfunction

	// modulo in pixels as the sum of the weights of the set control bits.
	function automatic int modulo_weight(input logic [7:0] ctl);
		return (ctl[3] ? 512 : 0) + (ctl[2] ? 256 : 0) + (ctl[0] ? 128 : 0)
			+ (ctl[6] ? 64 : 0) + (ctl[5] ? 32 : 0) + (ctl[4] ? 16 : 0);
	endfunction

	function automatic word_t madam_ref_read(input reg_offset_t ofs);
		word_t value;
		if (ofs == OFS_REVISION) begin
			return REVISION_VALUE;
		end
		if (ofs == OFS_MSYSBITS) begin
			return MSYSBITS_VALUE;
		end
		if (ofs == OFS_MCTL) begin
			return '0;		// enable word reads zero.
		end
		if (ofs == OFS_MSB_CHECK) begin
			return msb_index(model_msb);
		end
		if (!is_writable(ofs)) begin
			return UNMAPPED_VALUE;
		end
		value = model_regs.exists(ofs) ? model_regs[ofs] : '0;
		if (is_dma(ofs)) begin
			value = value & 32'h003F_FFFF;	// 22-bit field.
		end
		return value;
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, name, actual,
				expected);
			$display("Regression failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// compare process, cpu_dout is settled since the falling edge.
	always @(posedge clk_25m) begin
		if (check_en) begin
			check_value("cpu_dout", cpu_dout, madam_ref_read(cpu_addr[15:0]));
		end
	end

	// called right after a falling edge; returns at the next one.
	task automatic write_reg(input reg_offset_t ofs, input word_t data);
		cpu_addr = {16'h0000, ofs};
		cpu_din  = data;
		cpu_wr   = 1'b1;
		@(negedge clk_25m);
		cpu_wr = 1'b0;
		if (ofs == OFS_MSB_CHECK) begin
			model_msb = data;
		end else if (is_writable(ofs)) begin
			model_regs[ofs] = data;
		end
	endtask

	task automatic read_and_compare(input reg_offset_t ofs);
		cpu_addr = {16'h0000, ofs};
		check_en = 1'b1;
		@(negedge clk_25m);
		check_en = 1'b0;
	endtask

	task automatic verify_reset_state();
		word_t data;
		foreach (WRITABLE_OFS[i]) begin
			read_and_compare(WRITABLE_OFS[i]);
		end
		read_and_compare(OFS_REVISION);
		check_value("cpu_dout", cpu_dout, 32'h0102_0000);
		read_and_compare(OFS_MSYSBITS);
		check_value("cpu_dout", cpu_dout, 32'h0000_0029);
		read_and_compare(OFS_MSB_CHECK);
		random_bits(32, data);
		write_reg(OFS_MCTL, data | 32'h1);	// at least one bit set.
		read_and_compare(OFS_MCTL);
		check_value("cpu_dout", cpu_dout, 32'h0000_0000);
	endtask

	task automatic readback_sweep();
		word_t data;
		for (int r = 0; r < WRITE_ROUNDS; r++) begin
			foreach (WRITABLE_OFS[i]) begin
				random_bits(32, data);
				write_reg(WRITABLE_OFS[i], data);
				read_and_compare(WRITABLE_OFS[i]);
			end
		end
		random_bits(32, data);
		write_reg(16'h0180, data);	// hole in the map.
		read_and_compare(16'h0180);
		check_value("cpu_dout", cpu_dout, 32'hBADA_CCE5);
	endtask

	task automatic msb_finder_sweep();
		word_t data;
		word_t shift;
		write_reg(OFS_MSB_CHECK, 32'h8400_0000);
		read_and_compare(OFS_MSB_CHECK);
		check_value("cpu_dout", cpu_dout, 32'd31);
		write_reg(OFS_MSB_CHECK, 32'h0000_0000);
		read_and_compare(OFS_MSB_CHECK);
		check_value("cpu_dout", cpu_dout, 32'hFFFF_FFFF);
		for (int i = 0; i < MSB_COUNT; i++) begin
			random_bits(32, data);
			random_bits(5, shift);
			write_reg(OFS_MSB_CHECK, data >> shift);	// spreads the top bit around.
			read_and_compare(OFS_MSB_CHECK);
		end
	endtask

	task automatic modulo_sweep();
		word_t data;
		for (int i = 0; i < MOD_COUNT; i++) begin
			random_bits(32, data);
			write_reg(OFS_REGCTL0, data);
			check_value("rmod", word_t'(rmod), word_t'(modulo_weight(data[7:0])));
			check_value("wmod", word_t'(wmod), word_t'(modulo_weight(data[15:8])));
		end
	endtask

	// line start at T0, then one flag bit per cycle at T1 to T7.
	task automatic send_line(input logic [6:0] pattern);
		pcsc = 1'b0;
		@(negedge clk_25m);
		pcsc = 1'b1;
		@(negedge clk_25m);
		check_value("hcount", word_t'(hcount), 32'd0);
		for (int k = 1; k <= 7; k++) begin
			pcsc = pattern[k-1];
			@(negedge clk_25m);
			check_value("hcount", word_t'(hcount), word_t'(k));	// no restart mid pattern.
		end
		check_value("line_flags", word_t'(line_flags), word_t'({pattern, 1'b0}));
		pcsc = 1'b0;
	endtask

	initial begin
		word_t data;
		clk_25m    = 1'b0;
		reset_n    = 1'b0;
		cpu_addr   = '0;
		cpu_din    = '0;
		cpu_wr     = 1'b0;
		pcsc       = 1'b0;
		check_en   = 1'b0;
		model_msb  = '0;
		lfsr_state = LFSR_SEED;
		repeat (RESET_CYCLES) @(negedge clk_25m);
		check_value("hcount", word_t'(hcount), 32'd0);	// counter runs once released.
		check_value("line_flags", word_t'(line_flags), 32'd0);
		check_value("rmod", word_t'(rmod), 32'd0);
		check_value("wmod", word_t'(wmod), 32'd0);
		reset_n = 1'b1;
		@(negedge clk_25m);
		verify_reset_state();
		readback_sweep();
		msb_finder_sweep();
		modulo_sweep();
		send_line(7'b1010101);	// rising edges inside the pattern.
		send_line(7'b0101010);
		for (int i = 0; i < LINE_COUNT; i++) begin
			random_bits(7, data);
			send_line(data[6:0]);
		end
		@(negedge clk_25m);
		check_value("assert_fail_count",
			word_t'(madam_top_inst.madam_pcsc_capture_inst.madam_asserts_inst.assert_fail_count),
			32'd0);
		$display("Regression passed");
		$finish;
	end

	// watchdog, about twice the expected run length.
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule
